//--- llc_consts.svh
`ifndef LLC_CONSTS_SVH
`define LLC_CONSTS_SVH

// locallink word and remainder widths
`define LL_DATA_W 32
`define LL_REM_W 4

// command header and completion trailer share one length
`define HDR_WORDS 8

// header word carrying the op flags in bits 31..29
`define HDR_FLAG_IDX 4

// header word carrying the source length
`define HDR_LEN_IDX 5

// payload buffer entries
`define FIFO_DEPTH 16

`endif

//--- llc_pkg.sv
`include "llc_consts.svh"

package llc_pkg;

   // header word 4 on the way in, trailer word 4 on the way out
   typedef union packed {
      logic [`LL_DATA_W-1:0] raw;
      struct packed {
         logic                  op_comp;
         logic                  op_decomp;
         logic                  op_copy;
         // set once a copy has completed
         logic                  status;
         logic [`LL_DATA_W-5:0] rsvd;
      } f;
   } cpl_word_u;

endpackage

//--- ll_stream_if.sv
`include "llc_consts.svh"

// payload words between parser, fifo and framer
interface ll_stream_if;

   logic [`LL_DATA_W-1:0] data;
   logic [`LL_REM_W-1:0]  rem;
   logic                  sop;
   logic                  eop;
   logic                  valid;
   logic                  ready;

   // word moves when valid and ready are both high
   modport sender (
      output data,
      output rem,
      output sop,
      output eop,
      output valid,
      input  ready
   );

   modport receiver (
      input  data,
      input  rem,
      input  sop,
      input  eop,
      input  valid,
      output ready
   );

endinterface

//--- job_if.sv
`include "llc_consts.svh"

// one decoded command, parser to framer
interface job_if import llc_pkg::*; ();

   logic                  valid;
   logic                  ready;
   cpl_word_u             flags;
   logic [`LL_DATA_W-1:0] src_len;

   modport sender (
      output valid,
      output flags,
      output src_len,
      input  ready
   );

   modport receiver (
      input  valid,
      input  flags,
      input  src_len,
      output ready
   );

endinterface

//--- hdr_parser.sv
`include "llc_consts.svh"

module hdr_parser
   import llc_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`LL_DATA_W-1:0] tx_d,
   input  logic [`LL_REM_W-1:0]  tx_rem,
   input  logic                  tx_sof_n,
   input  logic                  tx_eof_n,
   input  logic                  tx_sop_n,
   input  logic                  tx_eop_n,
   input  logic                  tx_src_rdy_n,
   output logic                  tx_dst_rdy_n,
   ll_stream_if.sender           payload,
   job_if.sender                 job
);

   localparam int CNT_W = $clog2(`HDR_WORDS);
   localparam logic [CNT_W-1:0] FLAG_IDX = CNT_W'(`HDR_FLAG_IDX);
   localparam logic [CNT_W-1:0] LEN_IDX = CNT_W'(`HDR_LEN_IDX);
   localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`HDR_WORDS - 1);

   localparam logic [2:0] S_IDLE = 3'd0;
   localparam logic [2:0] S_HDR = 3'd1;
   localparam logic [2:0] S_JOB = 3'd2;
   localparam logic [2:0] S_PAYLOAD = 3'd3;
   localparam logic [2:0] S_END = 3'd4;

   logic [2:0]            state;
   logic [CNT_W-1:0]      hdr_cnt;
   cpl_word_u             flags_q;
   logic [`LL_DATA_W-1:0] len_q;
   logic                  xfer;
   logic                  is_copy;
   logic                  flag_capture;

   assign xfer = !tx_src_rdy_n && !tx_dst_rdy_n;
   assign is_copy = flags_q.f.op_copy;
   assign flag_capture = (state == S_HDR) && xfer && (hdr_cnt == FLAG_IDX);

   // stall the source while the job waits or the fifo is full
   always_comb begin
      case (state)
         S_JOB:     tx_dst_rdy_n = 1'b1;
         S_PAYLOAD: tx_dst_rdy_n = !payload.ready;
         default:   tx_dst_rdy_n = 1'b0;
      endcase
   end

   // payload goes straight into the fifo, only for copy jobs
   assign payload.data = tx_d;
   assign payload.rem = tx_rem;
   assign payload.sop = !tx_sop_n;
   assign payload.eop = !tx_eop_n;
   assign payload.valid = (state == S_PAYLOAD) && is_copy && !tx_src_rdy_n;

   assign job.valid = (state == S_JOB);
   assign job.flags = flags_q;
   assign job.src_len = len_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= S_IDLE;
         hdr_cnt <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               // header word 0 arrives with sof
               if (xfer && !tx_sof_n) begin
                  state <= S_HDR;
                  hdr_cnt <= CNT_W'(1);
               end
            end
            S_HDR: begin
               if (xfer) begin
                  hdr_cnt <= hdr_cnt + 1'b1;
                  if (hdr_cnt == LAST_IDX) begin
                     state <= S_JOB;
                  end
               end
            end
            S_JOB: begin
               if (job.ready) begin
                  state <= S_PAYLOAD;
               end
            end
            S_PAYLOAD: begin
               // eof may ride on the eop word or come later
               if (xfer && !tx_eop_n) begin
                  state <= tx_eof_n ? S_END : S_IDLE;
               end
            end
            S_END: begin
               if (xfer && !tx_eof_n) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (flag_capture) begin
         flags_q.raw <= tx_d;
      end
      if ((state == S_HDR) && xfer && (hdr_cnt == LEN_IDX)) begin
         len_q <= tx_d;
      end
   end

   a_flags_known: assert property (@(posedge clk) disable iff (!rst_n)
      flag_capture |=> !$isunknown({flags_q.f.op_comp, flags_q.f.op_decomp, flags_q.f.op_copy}));

endmodule

//--- payload_fifo.sv
`include "llc_consts.svh"

module payload_fifo #(
   parameter int DEPTH = `FIFO_DEPTH
) (
   input logic           clk,
   input logic           rst_n,
   ll_stream_if.receiver wr,
   ll_stream_if.sender   rd
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int EW = `LL_DATA_W + `LL_REM_W + 2;
   localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
   localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

   // entry is data, rem, sop, eop
   logic [EW-1:0] mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          wr_en;
   logic          rd_en;

   assign wr.ready = (count != FULL_CNT);
   assign rd.valid = (count != '0);
   assign wr_en = wr.valid && wr.ready;
   assign rd_en = rd.valid && rd.ready;

   // head of queue shows directly on the read side
   assign {rd.data, rd.rem, rd.sop, rd.eop} = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= {wr.data, wr.rem, wr.sop, wr.eop};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // a write lands only on a slot that was already read
   a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> (wr_ptr != rd_ptr || count == '0));

   // a read takes only a slot that was already written
   a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
      rd_en |-> (rd_ptr != wr_ptr || count == FULL_CNT));

endmodule

//--- cpl_framer.sv
`include "llc_consts.svh"

module cpl_framer
   import llc_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   ll_stream_if.receiver         payload,
   job_if.receiver               job,
   output logic [`LL_DATA_W-1:0] rx_d,
   output logic [`LL_REM_W-1:0]  rx_rem,
   output logic                  rx_sof_n,
   output logic                  rx_eof_n,
   output logic                  rx_sop_n,
   output logic                  rx_eop_n,
   output logic                  rx_src_rdy_n,
   input  logic                  rx_dst_rdy_n
);

   localparam int CNT_W = $clog2(`HDR_WORDS);
   localparam logic [CNT_W-1:0] FLAG_IDX = CNT_W'(`HDR_FLAG_IDX);
   localparam logic [CNT_W-1:0] LEN_IDX = CNT_W'(`HDR_LEN_IDX);
   localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`HDR_WORDS - 1);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_PAYLOAD = 2'd1;
   localparam logic [1:0] S_TRAILER = 2'd2;

   logic [1:0]            state;
   logic [CNT_W-1:0]      tr_cnt;
   logic                  sof_pend;
   cpl_word_u             flags_q;
   logic [`LL_DATA_W-1:0] len_q;
   cpl_word_u             cpl_w;
   logic [`LL_DATA_W-1:0] tr_word;
   logic                  is_copy;
   logic                  xfer;

   assign is_copy = flags_q.f.op_copy;
   assign xfer = !rx_src_rdy_n && !rx_dst_rdy_n;
   assign job.ready = (state == S_IDLE);
   assign payload.ready = (state == S_PAYLOAD) && !rx_dst_rdy_n;

   // flag echo, status only for a finished copy
   always_comb begin
      cpl_w = '0;
      cpl_w.f.op_comp = flags_q.f.op_comp;
      cpl_w.f.op_decomp = flags_q.f.op_decomp;
      cpl_w.f.op_copy = flags_q.f.op_copy;
      cpl_w.f.status = is_copy;
   end

   always_comb begin
      case (tr_cnt)
         FLAG_IDX: tr_word = cpl_w.raw;
         LEN_IDX:  tr_word = is_copy ? len_q : '0;
         default:  tr_word = '0;
      endcase
   end

   always_comb begin
      rx_d = '0;
      rx_rem = '0;
      rx_sop_n = 1'b1;
      rx_eop_n = 1'b1;
      rx_sof_n = !sof_pend;
      rx_eof_n = 1'b1;
      rx_src_rdy_n = 1'b1;
      case (state)
         S_PAYLOAD: begin
            rx_d = payload.data;
            rx_rem = payload.rem;
            rx_sop_n = !payload.sop;
            rx_eop_n = !payload.eop;
            rx_src_rdy_n = !payload.valid;
         end
         S_TRAILER: begin
            rx_d = tr_word;
            rx_eof_n = (tr_cnt != LAST_IDX);
            rx_src_rdy_n = 1'b0;
         end
         default: begin
            rx_src_rdy_n = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= S_IDLE;
         tr_cnt <= '0;
         sof_pend <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (job.valid) begin
                  // no payload to copy for compress or decompress
                  state <= job.flags.f.op_copy ? S_PAYLOAD : S_TRAILER;
                  tr_cnt <= '0;
                  sof_pend <= 1'b1;
               end
            end
            S_PAYLOAD: begin
               if (xfer) begin
                  sof_pend <= 1'b0;
                  if (payload.eop) begin
                     state <= S_TRAILER;
                  end
               end
            end
            S_TRAILER: begin
               if (xfer) begin
                  sof_pend <= 1'b0;
                  tr_cnt <= tr_cnt + 1'b1;
                  if (tr_cnt == LAST_IDX) begin
                     state <= S_IDLE;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (job.valid && job.ready) begin
         flags_q <= job.flags;
         len_q <= job.src_len;
      end
   end

   // an offered word stays put through sink back-pressure, fifo head included
   a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_src_rdy_n && rx_dst_rdy_n) |=> (!rx_src_rdy_n && $stable(rx_d)));

endmodule

//--- copy_engine.sv
`include "llc_consts.svh"

module copy_engine (
   input  logic                  clk,
   input  logic                  rst_n,
   // locallink input frames
   input  logic [`LL_DATA_W-1:0] tx_d,
   input  logic [`LL_REM_W-1:0]  tx_rem,
   input  logic                  tx_sof_n,
   input  logic                  tx_eof_n,
   input  logic                  tx_sop_n,
   input  logic                  tx_eop_n,
   input  logic                  tx_src_rdy_n,
   output logic                  tx_dst_rdy_n,
   // locallink output frames
   output logic [`LL_DATA_W-1:0] rx_d,
   output logic [`LL_REM_W-1:0]  rx_rem,
   output logic                  rx_sof_n,
   output logic                  rx_eof_n,
   output logic                  rx_sop_n,
   output logic                  rx_eop_n,
   output logic                  rx_src_rdy_n,
   input  logic                  rx_dst_rdy_n
);

   ll_stream_if payload_in ();
   ll_stream_if payload_out ();
   job_if job ();

   hdr_parser i_hdr_parser (
      .clk          (clk),
      .rst_n        (rst_n),
      .tx_d         (tx_d),
      .tx_rem       (tx_rem),
      .tx_sof_n     (tx_sof_n),
      .tx_eof_n     (tx_eof_n),
      .tx_sop_n     (tx_sop_n),
      .tx_eop_n     (tx_eop_n),
      .tx_src_rdy_n (tx_src_rdy_n),
      .tx_dst_rdy_n (tx_dst_rdy_n),
      .payload      (payload_in.sender),
      .job          (job.sender)
   );

   payload_fifo #(
      .DEPTH (`FIFO_DEPTH)
   ) i_payload_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (payload_in.receiver),
      .rd    (payload_out.sender)
   );

   cpl_framer i_cpl_framer (
      .clk          (clk),
      .rst_n        (rst_n),
      .payload      (payload_out.receiver),
      .job          (job.receiver),
      .rx_d         (rx_d),
      .rx_rem       (rx_rem),
      .rx_sof_n     (rx_sof_n),
      .rx_eof_n     (rx_eof_n),
      .rx_sop_n     (rx_sop_n),
      .rx_eop_n     (rx_eop_n),
      .rx_src_rdy_n (rx_src_rdy_n),
      .rx_dst_rdy_n (rx_dst_rdy_n)
   );

endmodule

//--- tb_copy_engine.sv
`include "llc_consts.svh"

module tb_copy_engine;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_TESTS = 7;
   localparam int TIMEOUT = 5000;

   typedef struct packed {
      logic [`LL_DATA_W-1:0] d;
      logic [`LL_REM_W-1:0]  rem;
      logic                  sof;
      logic                  eof;
      logic                  sop;
      logic                  eop;
   } ll_word_t;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic [`LL_DATA_W-1:0] tx_d;
   logic [`LL_REM_W-1:0]  tx_rem;
   logic                  tx_sof_n;
   logic                  tx_eof_n;
   logic                  tx_sop_n;
   logic                  tx_eop_n;
   logic                  tx_src_rdy_n;
   logic                  tx_dst_rdy_n;
   logic [`LL_DATA_W-1:0] rx_d;
   logic [`LL_REM_W-1:0]  rx_rem;
   logic                  rx_sof_n;
   logic                  rx_eof_n;
   logic                  rx_sop_n;
   logic                  rx_eop_n;
   logic                  rx_src_rdy_n;
   logic                  rx_dst_rdy_n;

   // stimulus table, one row per test, stalls in percent
   string       t_name [N_TESTS];
   logic [2:0]  t_flags [N_TESTS];
   logic [31:0] t_len [N_TESTS];
   int          t_plen [N_TESTS];
   logic [31:0] t_base [N_TESTS];
   logic [3:0]  t_rem [N_TESTS];
   int          t_frames [N_TESTS];
   int          t_src_stall [N_TESTS];
   int          t_snk_stall [N_TESTS];

   ll_word_t exp_q [$];
   ll_word_t got_q [$];
   int       seed;
   bit       timed_out;
   int       tests_run;
   int       tests_bad;
   int       total_errs;

   always #4 clk = ~clk;

   copy_engine i_copy_engine (.*);

   task automatic set_row(int i, string name, logic [2:0] flags, logic [31:0] len, int plen,
                          logic [31:0] base, logic [3:0] rem, int frames, int src, int snk);
      t_name[i] = name;
      t_flags[i] = flags;
      t_len[i] = len;
      t_plen[i] = plen;
      t_base[i] = base;
      t_rem[i] = rem;
      t_frames[i] = frames;
      t_src_stall[i] = src;
      t_snk_stall[i] = snk;
   endtask

   function automatic bit stall_roll(int prob);
      logic [31:0] r;
      r = $random(seed);
      return (r % 32'd100) < 32'(prob);
   endfunction

   function automatic logic [31:0] payload_word(int row, int frame, int idx);
      return t_base[row] + (32'(frame) << 20) + (32'(idx) * 32'h0001_0101);
   endfunction

   // flag word carries junk in the low bits, the trailer must not echo it
   function automatic logic [31:0] header_word(int row, int idx);
      if (idx == `HDR_FLAG_IDX) return {t_flags[row], 29'h00ab_cdef};
      if (idx == `HDR_LEN_IDX) return t_len[row];
      return 32'hc0de_0000 + 32'(idx);
   endfunction

   function automatic logic [31:0] trailer_word(int row, int idx);
      logic [31:0] w;
      w = '0;
      if (idx == `HDR_FLAG_IDX) begin
         w[31:29] = t_flags[row];
         w[28] = t_flags[row][0];
      end else if (idx == `HDR_LEN_IDX && t_flags[row][0]) begin
         w = t_len[row];
      end
      return w;
   endfunction

   task automatic build_expected(int row);
      int       f;
      int       i;
      ll_word_t w;
      exp_q.delete();
      for (f = 0; f < t_frames[row]; f++) begin
         if (t_flags[row][0]) begin
            for (i = 0; i < t_plen[row]; i++) begin
               w.d = payload_word(row, f, i);
               w.rem = (i == t_plen[row] - 1) ? t_rem[row] : 4'hf;
               w.sof = (i == 0);
               w.eof = 1'b0;
               w.sop = (i == 0);
               w.eop = (i == t_plen[row] - 1);
               exp_q.push_back(w);
            end
         end
         for (i = 0; i < `HDR_WORDS; i++) begin
            w.d = trailer_word(row, i);
            w.rem = '0;
            w.sof = !t_flags[row][0] && (i == 0);
            w.eof = (i == `HDR_WORDS - 1);
            w.sop = 1'b0;
            w.eop = 1'b0;
            exp_q.push_back(w);
         end
      end
   endtask

   task automatic drive_word(int row, int frame, int k);
      int p;
      p = k - `HDR_WORDS;
      if (k < `HDR_WORDS) begin
         tx_d = header_word(row, k);
         tx_rem = 4'hf;
      end else begin
         tx_d = payload_word(row, frame, p);
         tx_rem = (p == t_plen[row] - 1) ? t_rem[row] : 4'hf;
      end
      tx_sof_n = (k != 0);
      tx_eof_n = (p != t_plen[row] - 1);
      tx_sop_n = (p != 0);
      tx_eop_n = (p != t_plen[row] - 1);
   endtask

   // an offered word is held until it transfers
   task automatic send_frames(int row);
      int   f;
      int   k;
      int   cycles;
      logic offering;
      logic accepted;
      for (f = 0; f < t_frames[row] && !timed_out; f++) begin
         k = 0;
         cycles = 0;
         offering = 1'b0;
         while (k < `HDR_WORDS + t_plen[row] && !timed_out) begin
            if (!offering && !stall_roll(t_src_stall[row])) begin
               drive_word(row, f, k);
               tx_src_rdy_n = 1'b0;
               offering = 1'b1;
            end
            @(negedge clk);
            accepted = offering && !tx_dst_rdy_n;
            @(posedge clk);
            #1;
            if (accepted) begin
               k++;
               offering = 1'b0;
               tx_src_rdy_n = 1'b1;
            end
            cycles++;
            if (cycles > TIMEOUT) begin
               $display("timeout: DUT never took input word %0d in %s", k, t_name[row]);
               timed_out = 1'b1;
            end
         end
      end
      tx_src_rdy_n = 1'b1;
   endtask

   task automatic collect_frames(int row);
      int       eofs;
      int       cycles;
      logic     next_rdy_n;
      ll_word_t w;
      eofs = 0;
      cycles = 0;
      got_q.delete();
      rx_dst_rdy_n = 1'b0;
      while (eofs < t_frames[row] && !timed_out) begin
         @(negedge clk);
         if (!rx_src_rdy_n && !rx_dst_rdy_n) begin
            w = {rx_d, rx_rem, !rx_sof_n, !rx_eof_n, !rx_sop_n, !rx_eop_n};
            got_q.push_back(w);
            if (!rx_eof_n) eofs++;
         end
         next_rdy_n = stall_roll(t_snk_stall[row]);
         @(posedge clk);
         #1;
         rx_dst_rdy_n = next_rdy_n;
         cycles++;
         if (cycles > TIMEOUT && eofs < t_frames[row]) begin
            $display("timeout: no end-of-frame came out of the DUT in %s", t_name[row]);
            timed_out = 1'b1;
         end
      end
      rx_dst_rdy_n = 1'b0;
   endtask

   task automatic check_frame(int row, inout int errs);
      int i;
      int n;
      assert (got_q.size() == exp_q.size()) else begin
         $display("[ERROR] %s word count: expected %0d, actual %0d",
                  t_name[row], exp_q.size(), got_q.size());
         errs++;
      end
      n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
      for (i = 0; i < n; i++) begin
         assert (got_q[i] === exp_q[i]) else begin
            $display("[ERROR] %s word %0d: expected %h, actual %h",
                     t_name[row], i, exp_q[i], got_q[i]);
            errs++;
         end
      end
      assert (rx_src_rdy_n === 1'b1) else begin
         $display("[ERROR] %s after end-of-frame: expected rx_src_rdy_n 1, actual %b",
                  t_name[row], rx_src_rdy_n);
         errs++;
      end
   endtask

   initial begin
      int row;
      int errs;
      seed = 32'h896;
      rst_n = 1'b0;
      tx_d = '0;
      tx_rem = '0;
      tx_sof_n = 1'b1;
      tx_eof_n = 1'b1;
      tx_sop_n = 1'b1;
      tx_eop_n = 1'b1;
      tx_src_rdy_n = 1'b1;
      rx_dst_rdy_n = 1'b0;
      set_row(0, "copy_short", 3'b001, 32'd16, 4, 32'h1000_0000, 4'h3, 1, 0, 0);
      set_row(1, "compress", 3'b100, 32'd64, 6, 32'h2000_0000, 4'h1, 1, 0, 0);
      set_row(2, "decompress", 3'b010, 32'd12, 3, 32'h3000_0000, 4'h7, 1, 0, 0);
      set_row(3, "copy_stalls", 3'b001, 32'd40, 10, 32'h4000_0000, 4'hf, 1, 30, 40);
      set_row(4, "copy_b2b", 3'b001, 32'd20, 5, 32'h5000_0000, 4'h1, 2, 10, 20);
      set_row(5, "copy_long", 3'b001, 32'd160, 40, 32'h6000_0000, 4'h7, 1, 10, 60);
      set_row(6, "comp_stalls", 3'b100, 32'd28, 7, 32'h7000_0000, 4'h3, 1, 40, 40);
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      // idle outputs before any input
      errs = 0;
      assert ({rx_src_rdy_n, rx_sof_n, rx_eof_n, rx_sop_n, rx_eop_n, tx_dst_rdy_n} === 6'b111110)
      else begin
         $display("[ERROR] reset_idle: expected 111110, actual %b",
                  {rx_src_rdy_n, rx_sof_n, rx_eof_n, rx_sop_n, rx_eop_n, tx_dst_rdy_n});
         errs++;
      end
      $display("reset_idle: %0d errors", errs);
      tests_run++;
      tests_bad += (errs != 0);
      total_errs += errs;
      for (row = 0; row < N_TESTS && !timed_out; row++) begin
         errs = 0;
         build_expected(row);
         fork
            send_frames(row);
            collect_frames(row);
         join
         if (timed_out) errs++;
         else check_frame(row, errs);
         $display("%s: %0d words, %0d errors", t_name[row], got_q.size(), errs);
         tests_run++;
         tests_bad += (errs != 0);
         total_errs += errs;
      end
      $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_bad, total_errs);
      if (total_errs == 0 && !timed_out) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+.
llc_pkg.sv
ll_stream_if.sv
job_if.sv
hdr_parser.sv
payload_fifo.sv
cpl_framer.sv
copy_engine.sv
tb_copy_engine.sv

//--- run.sh
#!/usr/bin/env bash
# build the copy engine testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_copy_engine -f filelist.f -o sim_copy_engine
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_copy_engine)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "test passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
